// File: logic/xbuf_pkg.sv
package xbuf_pkg;

  // data word width
  localparam int unsigned WORD_W = 16;

  // tile geometry, rows are written and columns are read
  localparam int unsigned ROWS = 4; // words per column beat
  localparam int unsigned COLS = 4; // words per row

  localparam int unsigned ROW_AW = $clog2(ROWS);
  localparam int unsigned COL_AW = $clog2(COLS);

endpackage : xbuf_pkg

// File: logic/x_row_loader.sv
module x_row_loader
  import xbuf_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         word_valid_i,
  input  logic [WORD_W-1:0]            word_i,
  input  logic                         tile_done_i,
  output logic                         write_en_o,
  output logic [ROW_AW-1:0]            write_addr_o,
  output logic [COLS-1:0][WORD_W-1:0]  wdata_o,
  output logic                         tile_full_o,
  output logic                         drop_o
);

  logic [COL_AW-1:0]           col_cnt_q;
  logic [ROW_AW-1:0]           row_cnt_q;
  logic [COLS-1:0][WORD_W-1:0] row_q;
  logic                        lock_q;
  logic                        write_en_q;
  logic [ROW_AW-1:0]           write_addr_q;
  logic                        tile_full_q;
  logic                        drop_q;

  logic accept;
  logic row_last;
  logic tile_last;

  assign accept    = word_valid_i & ~lock_q & ~clear_i;
  assign row_last  = accept & (col_cnt_q == COL_AW'(COLS - 1));
  assign tile_last = row_last & (row_cnt_q == ROW_AW'(ROWS - 1));

  // one word slot per accepted word
  always_ff @(posedge clk_i or negedge rst_ni) begin : partial_row
    if (~rst_ni) begin
      row_q <= '0;
    end else if (clear_i) begin
      row_q <= '0;
    end else if (accept) begin
      row_q[col_cnt_q] <= word_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : counters
    if (~rst_ni) begin
      col_cnt_q <= '0;
      row_cnt_q <= '0;
    end else if (clear_i) begin
      col_cnt_q <= '0;
      row_cnt_q <= '0;
    end else if (accept) begin
      if (row_last) begin
        col_cnt_q <= '0;
        row_cnt_q <= tile_last ? '0 : row_cnt_q + 1'b1;
      end else begin
        col_cnt_q <= col_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : lock_ctrl
    if (~rst_ni) begin
      lock_q <= 1'b0;
    end else if (clear_i || tile_done_i) begin
      lock_q <= 1'b0; // feeder has drained the tile
    end else if (tile_last) begin
      lock_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : strobes
    if (~rst_ni) begin
      write_en_q   <= 1'b0;
      write_addr_q <= '0;
      tile_full_q  <= 1'b0;
      drop_q       <= 1'b0;
    end else if (clear_i) begin
      write_en_q   <= 1'b0;
      write_addr_q <= '0;
      tile_full_q  <= 1'b0;
      drop_q       <= 1'b0;
    end else begin
      write_en_q  <= row_last;
      tile_full_q <= write_en_q & (write_addr_q == ROW_AW'(ROWS - 1));
      drop_q      <= word_valid_i & lock_q;
      if (row_last) begin
        write_addr_q <= row_cnt_q;
      end
    end
  end

  assign write_en_o   = write_en_q & ~clear_i;
  assign write_addr_o = write_addr_q;
  assign wdata_o      = row_q; // complete row in the cycle after its last word
  assign tile_full_o  = tile_full_q & ~clear_i;
  assign drop_o       = drop_q & ~clear_i;

  // release only arrives for a locked tile
  a_done_only_when_locked : assert property (
    @(posedge clk_i) disable iff (~rst_ni)
    tile_done_i |-> lock_q
  ) else $error("tile done while tile not locked");

endmodule : x_row_loader

// File: logic/x_tile_buffer.sv
module x_tile_buffer
  import xbuf_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         write_en_i,
  input  logic [ROW_AW-1:0]            write_addr_i,
  input  logic [COLS-1:0][WORD_W-1:0]  wdata_i,
  input  logic                         read_en_i,
  input  logic [COL_AW-1:0]            read_addr_i,
  output logic [ROWS-1:0][WORD_W-1:0]  rdata_o
);

  logic [ROWS-1:0][COLS-1:0][WORD_W-1:0] store_q;
  logic [COL_AW-1:0]                     read_addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : sample_raddr
    if (~rst_ni) begin
      read_addr_q <= '0;
    end else if (clear_i) begin
      read_addr_q <= '0;
    end else if (read_en_i) begin
      read_addr_q <= read_addr_i;
    end
  end

  for (genvar r = 0; r < ROWS; r++) begin : gen_rows
    // whole row written at once
    always_ff @(posedge clk_i or negedge rst_ni) begin : row_store
      if (~rst_ni) begin
        store_q[r] <= '0;
      end else if (clear_i) begin
        store_q[r] <= '0;
      end else if (write_en_i && (write_addr_i == ROW_AW'(r))) begin
        store_q[r] <= wdata_i;
      end
    end

    assign rdata_o[r] = store_q[r][read_addr_q]; // same column from every row
  end

  a_write_addr_range : assert property (
    @(posedge clk_i) disable iff (~rst_ni)
    write_en_i |-> (int'(write_addr_i) < ROWS)
  ) else $error("write address out of range");

  a_read_addr_range : assert property (
    @(posedge clk_i) disable iff (~rst_ni)
    read_en_i |-> (int'(read_addr_i) < COLS)
  ) else $error("read address out of range");

endmodule : x_tile_buffer

// File: logic/x_col_feeder.sv
module x_col_feeder
  import xbuf_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         tile_full_i,
  input  logic [ROWS-1:0][WORD_W-1:0]  rdata_i,
  output logic                         read_en_o,
  output logic [COL_AW-1:0]            read_addr_o,
  output logic                         col_valid_o,
  output logic [COL_AW-1:0]            col_idx_o,
  output logic [ROWS-1:0][WORD_W-1:0]  col_o,
  output logic                         tile_done_o
);

  logic              active_q;
  logic [COL_AW-1:0] col_cnt_q;
  logic              valid_q;
  logic [COL_AW-1:0] col_idx_q;
  logic              done_q;

  logic last_read;

  assign read_en_o   = active_q & ~clear_i;
  assign read_addr_o = col_cnt_q;
  assign last_read   = read_en_o & (col_cnt_q == COL_AW'(COLS - 1));

  // sweep over all columns, one read per cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin : sweep
    if (~rst_ni) begin
      active_q  <= 1'b0;
      col_cnt_q <= '0;
    end else if (clear_i) begin
      active_q  <= 1'b0;
      col_cnt_q <= '0;
    end else begin
      if (tile_full_i) begin
        active_q <= 1'b1;
      end else if (last_read) begin
        active_q <= 1'b0;
      end
      if (read_en_o) begin
        col_cnt_q <= last_read ? '0 : col_cnt_q + 1'b1;
      end
    end
  end

  // read data lands one cycle after the address
  always_ff @(posedge clk_i or negedge rst_ni) begin : align
    if (~rst_ni) begin
      valid_q   <= 1'b0;
      col_idx_q <= '0;
      done_q    <= 1'b0;
    end else if (clear_i) begin
      valid_q   <= 1'b0;
      col_idx_q <= '0;
      done_q    <= 1'b0;
    end else begin
      valid_q   <= read_en_o;
      col_idx_q <= col_cnt_q;
      done_q    <= last_read;
    end
  end

  assign col_valid_o = valid_q & ~clear_i;
  assign col_idx_o   = col_idx_q;
  assign col_o       = rdata_i;
  assign tile_done_o = done_q & ~clear_i; // releases the loader lock

  // loader lock must hold off a new tile until the sweep ends
  a_no_full_during_sweep : assert property (
    @(posedge clk_i) disable iff (~rst_ni)
    tile_full_i |-> !active_q
  ) else $error("tile full during column sweep");

endmodule : x_col_feeder

// File: logic/x_transpose_top.sv
module x_transpose_top
  import xbuf_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         word_valid_i,
  input  logic [WORD_W-1:0]            word_i,
  output logic                         col_valid_o,
  output logic [COL_AW-1:0]            col_idx_o,
  output logic [ROWS-1:0][WORD_W-1:0]  col_o,
  output logic                         drop_o
);

  logic                        write_en;
  logic [ROW_AW-1:0]           write_addr;
  logic [COLS-1:0][WORD_W-1:0] wdata;
  logic                        tile_full;
  logic                        tile_done;
  logic                        read_en;
  logic [COL_AW-1:0]           read_addr;
  logic [ROWS-1:0][WORD_W-1:0] rdata;

  x_row_loader i_x_row_loader (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( clear_i      ),
    .word_valid_i ( word_valid_i ),
    .word_i       ( word_i       ),
    .tile_done_i  ( tile_done    ),
    .write_en_o   ( write_en     ),
    .write_addr_o ( write_addr   ),
    .wdata_o      ( wdata        ),
    .tile_full_o  ( tile_full    ),
    .drop_o       ( drop_o       )
  );

  x_tile_buffer i_x_tile_buffer (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .write_en_i   ( write_en   ),
    .write_addr_i ( write_addr ),
    .wdata_i      ( wdata      ),
    .read_en_i    ( read_en    ),
    .read_addr_i  ( read_addr  ),
    .rdata_o      ( rdata      )
  );

  x_col_feeder i_x_col_feeder (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .tile_full_i ( tile_full   ),
    .rdata_i     ( rdata       ),
    .read_en_o   ( read_en     ),
    .read_addr_o ( read_addr   ),
    .col_valid_o ( col_valid_o ),
    .col_idx_o   ( col_idx_o   ),
    .col_o       ( col_o       ),
    .tile_done_o ( tile_done   )
  );

endmodule : x_transpose_top

// File: dv/tb_x_transpose.sv
module tb_x_transpose
  import xbuf_pkg::*;
();

  localparam int NUM_TILES       = 40;
  localparam int CYCLES_PER_TILE = 40;
  localparam int TIMEOUT_CYCLES  = NUM_TILES * CYCLES_PER_TILE;
  localparam int TILE_WORDS      = ROWS * COLS;
  localparam int FIRST_BEAT      = 4;        // cycles from last word to column 0
  localparam int LOCK_LAST       = 3 + COLS; // last locked cycle, tile_done
  localparam int QUIET_CYCLES    = 6;

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic                        clear;
  logic                        word_valid;
  logic [WORD_W-1:0]           word;
  logic                        col_valid;
  logic [COL_AW-1:0]           col_idx;
  logic [ROWS-1:0][WORD_W-1:0] col;
  logic                        drop;

  // reference model state
  logic [WORD_W-1:0] partial [TILE_WORDS];
  logic [WORD_W-1:0] tile_words [TILE_WORDS];
  int                fill;        // words accepted into the open tile
  int                age;         // cycles since last word of a tile, -1 when unlocked
  bit                drop_pend;
  bit                store_empty;
  int                tiles_done;

  logic [31:0] seed;
  int          errors;
  int          checks;
  int          cycle_cnt;

  x_transpose_top i_x_transpose_top (
    .clk_i        ( clk        ),
    .rst_ni       ( rst_n      ),
    .clear_i      ( clear      ),
    .word_valid_i ( word_valid ),
    .word_i       ( word       ),
    .col_valid_o  ( col_valid  ),
    .col_idx_o    ( col_idx    ),
    .col_o        ( col        ),
    .drop_o       ( drop       )
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // row r of column c holds word r*COLS+c of the tile
  function automatic logic [ROWS-1:0][WORD_W-1:0] expected_column(input int c);
    logic [ROWS-1:0][WORD_W-1:0] v;
    for (int r = 0; r < ROWS; r++) begin
      v[r] = tile_words[r * COLS + c];
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  // one clock cycle: drive, check outputs, then advance the model
  task automatic run_cycle(input bit quiet);
    logic [31:0]       r;
    logic [WORD_W-1:0] w;
    bit                do_clear;
    bit                do_word;
    bit                locked;
    bit                beat;
    int                c;
    @(negedge clk);
    seed = lcg_next(seed);
    r = seed;
    seed = lcg_next(seed);
    w = seed[31 -: WORD_W];
    do_clear = !quiet && (r[31:25] == 7'd0); // about 1 in 128
    do_word  = !quiet && (r[24:23] != 2'd0); // about 3 in 4
    clear      = do_clear;
    word_valid = do_word;
    word       = w;
    #1;
    locked = (age >= 1);
    beat   = !do_clear && (age >= FIRST_BEAT);
    check_value("col_valid_o", 64'(beat), 64'(col_valid));
    if (beat) begin
      c = age - FIRST_BEAT;
      check_value("col_idx_o", 64'(c), 64'(col_idx));
      check_value("col_o", 64'(expected_column(c)), 64'(col));
    end
    check_value("drop_o", 64'(drop_pend && !do_clear), 64'(drop));
    if (store_empty) begin
      check_value("col_o", '0, 64'(col)); // nothing written since reset or clear
    end
    if (do_clear) begin
      fill        = 0;
      age         = -1;
      drop_pend   = 1'b0;
      store_empty = 1'b1;
    end else begin
      drop_pend = do_word && locked;
      if (locked) begin
        if (age == LOCK_LAST) begin
          age = -1;
          tiles_done++;
        end else begin
          age++;
        end
      end else if (do_word) begin
        partial[fill] = w;
        fill++;
        if (fill % COLS == 0) begin
          store_empty = 1'b0;
        end
        if (fill == TILE_WORDS) begin
          tile_words = partial;
          fill       = 0;
          age        = 1;
        end
      end
    end
  endtask

  initial begin : stimulus
    int i;
    rst_n       = 1'b0;
    clear       = 1'b0;
    word_valid  = 1'b0;
    word        = '0;
    seed        = 32'ha0fe;
    errors      = 0;
    checks      = 0;
    fill        = 0;
    age         = -1;
    drop_pend   = 1'b0;
    store_empty = 1'b1;
    tiles_done  = 0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    for (i = 0; i < QUIET_CYCLES; i++) begin
      run_cycle(1'b1); // outputs must stay idle after reset
    end
    while (tiles_done < NUM_TILES) begin
      run_cycle(1'b0);
    end
    for (i = 0; i < QUIET_CYCLES; i++) begin
      run_cycle(1'b1);
    end
    $display("tiles: %0d, checks: %0d, errors: %0d", tiles_done, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    errors++;
    $display("timeout: only %0d of %0d tiles completed within %0d cycles",
             tiles_done, NUM_TILES, TIMEOUT_CYCLES);
    $display("tiles: %0d, checks: %0d, errors: %0d", tiles_done, checks, errors);
    $display("Errors found");
    $finish;
  end

endmodule : tb_x_transpose

// File: flist.f
logic/xbuf_pkg.sv
logic/x_row_loader.sv
logic/x_tile_buffer.sv
logic/x_col_feeder.sv
logic/x_transpose_top.sv
dv/tb_x_transpose.sv

// File: Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert
TOP        := tb_x_transpose
RTL_TOP    := x_transpose_top
FLIST      := flist.f
OBJ_DIR    := obj_dir
PASS_MSG   := No errors

SIM_BIN    := $(OBJ_DIR)/V$(TOP)
SOURCES    := $(shell cat $(FLIST))

.PHONY: all lint sim clean

all: sim

# lint the design top level
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# pass only when the pass message shows up in the output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
